// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;	// register index
	localparam int num_gprs   = 32;

	// instruction field positions and widths
	localparam int opcode_lsb = 0;
	localparam int rd_lsb     = 7;
	localparam int funct3_lsb = 12;
	localparam int rs1_lsb    = 15;
	localparam int rs2_lsb    = 20;
	localparam int funct7_lsb = 25;
	localparam int opcode_w   = 7;
	localparam int funct3_w   = 3;
	localparam int funct7_w   = 7;

	// base integer opcodes
	localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
	localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
	localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
	localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
	localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
	localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
	localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
	localparam logic [opcode_w-1:0] op_alu_ir = 7'b0010011;
	localparam logic [opcode_w-1:0] op_alu_rr = 7'b0110011;

	localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
	localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000;	// sub, sra

	// funct3 codes for branches
	localparam logic [funct3_w-1:0] f3_beq  = 3'b000;
	localparam logic [funct3_w-1:0] f3_bne  = 3'b001;
	localparam logic [funct3_w-1:0] f3_blt  = 3'b100;
	localparam logic [funct3_w-1:0] f3_bge  = 3'b101;
	localparam logic [funct3_w-1:0] f3_bltu = 3'b110;
	localparam logic [funct3_w-1:0] f3_bgeu = 3'b111;

	// alu funct3 codes that also accept f7_alt
	localparam logic [funct3_w-1:0] f3_add = 3'b000;
	localparam logic [funct3_w-1:0] f3_sr  = 3'b101;

endpackage

// File: hw/dec_pipe_pkg.sv
package dec_pipe_pkg;

	typedef struct packed {
		logic                        valid;
		logic [rv_isa_pkg::xlen-1:0] instr;
		logic [rv_isa_pkg::xlen-1:0] pc;
		logic [rv_isa_pkg::xlen-1:0] pc_plus4;
	} fetch_pkt_t;

	// none sits at zero so a cleared packet reads as a nop
	typedef enum logic [3:0] {
		alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
		alu_or, alu_xor, alu_sll, alu_srl, alu_sra
	} alu_op_t;

	typedef enum logic [2:0] {
		br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
	} br_op_t;

	// encoded like funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		mem_byte, mem_half, mem_word
	} mem_size_t;

	typedef enum logic [2:0] {
		imm_i, imm_s, imm_b, imm_u, imm_j
	} imm_fmt_t;

	typedef struct packed {
		alu_op_t   alu_op;
		br_op_t    br_op;
		logic      jal;
		logic      jalr;
		logic      load;
		logic      store;
		logic      illegal;
		mem_size_t mem_size;
		logic      mem_unsigned;
		logic      use_rs1;
		logic      use_rs2_as_src2;
		logic      use_imm_as_src2;
		logic      src1_is_pc;		// auipc
		logic      src2_is_link;	// jal, jalr
		logic      rd_write;
		imm_fmt_t  imm_fmt;
	} dec_ctrl_t;

	// result of a later stage, also the writeback port
	typedef struct packed {
		logic                              valid;
		logic [rv_isa_pkg::reg_addr_w-1:0] rd;
		logic [rv_isa_pkg::xlen-1:0]       data;
	} fwd_t;

	typedef struct packed {
		logic                              valid;
		alu_op_t                           alu_op;
		br_op_t                            br_op;
		logic                              jalr;
		logic                              load;
		logic                              store;
		mem_size_t                         mem_size;
		logic                              mem_unsigned;
		logic                              illegal;
		logic                              rd_write;
		logic [rv_isa_pkg::reg_addr_w-1:0] rd;
		logic [rv_isa_pkg::xlen-1:0]       src1;
		logic [rv_isa_pkg::xlen-1:0]       src2;
		logic [rv_isa_pkg::xlen-1:0]       store_data;
		logic [rv_isa_pkg::xlen-1:0]       imm;
		logic [rv_isa_pkg::xlen-1:0]       pc;
		logic [rv_isa_pkg::xlen-1:0]       pc_plus4;
	} ex_pkt_t;

endpackage

// File: hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  logic [rv_isa_pkg::xlen-1:0] instr,
	output dec_pipe_pkg::dec_ctrl_t     ctrl
);

	logic [rv_isa_pkg::opcode_w-1:0] opcode;
	logic [rv_isa_pkg::funct3_w-1:0] funct3;
	logic [rv_isa_pkg::funct7_w-1:0] funct7;
	logic                            rr_legal;	// funct7 allowed on a reg-reg op

	assign opcode = instr[rv_isa_pkg::opcode_lsb +: rv_isa_pkg::opcode_w];
	assign funct3 = instr[rv_isa_pkg::funct3_lsb +: rv_isa_pkg::funct3_w];
	assign funct7 = instr[rv_isa_pkg::funct7_lsb +: rv_isa_pkg::funct7_w];

	assign rr_legal = (funct7 == rv_isa_pkg::f7_base) ||
		((funct7 == rv_isa_pkg::f7_alt) &&
		 ((funct3 == rv_isa_pkg::f3_add) || (funct3 == rv_isa_pkg::f3_sr)));

	// alt selects sub / sra
	function automatic dec_pipe_pkg::alu_op_t alu_fn(
		input logic [rv_isa_pkg::funct3_w-1:0] f3,
		input logic                            alt
	);
		case (f3)
			3'b000: alu_fn = alt ? dec_pipe_pkg::alu_sub : dec_pipe_pkg::alu_add;
			3'b001: alu_fn = dec_pipe_pkg::alu_sll;
			3'b010: alu_fn = dec_pipe_pkg::alu_slt;
			3'b011: alu_fn = dec_pipe_pkg::alu_sltu;
			3'b100: alu_fn = dec_pipe_pkg::alu_xor;
			3'b101: alu_fn = alt ? dec_pipe_pkg::alu_sra : dec_pipe_pkg::alu_srl;
			3'b110: alu_fn = dec_pipe_pkg::alu_or;
			default: alu_fn = dec_pipe_pkg::alu_and;
		endcase
	endfunction

	always_comb
	begin
		ctrl          = '0;
		ctrl.alu_op   = dec_pipe_pkg::alu_add;	// most formats compute an address or sum
		ctrl.br_op    = dec_pipe_pkg::br_none;
		ctrl.mem_size = dec_pipe_pkg::mem_size_t'(funct3[1:0]);
		ctrl.imm_fmt  = dec_pipe_pkg::imm_i;
		case (opcode)
			rv_isa_pkg::op_lui:
			begin
				ctrl.use_imm_as_src2 = 1'b1;	// 0 + imm
				ctrl.rd_write        = 1'b1;
				ctrl.imm_fmt         = dec_pipe_pkg::imm_u;
			end
			rv_isa_pkg::op_auipc:
			begin
				ctrl.src1_is_pc      = 1'b1;
				ctrl.use_imm_as_src2 = 1'b1;
				ctrl.rd_write        = 1'b1;
				ctrl.imm_fmt         = dec_pipe_pkg::imm_u;
			end
			rv_isa_pkg::op_jal:
			begin
				ctrl.jal          = 1'b1;
				ctrl.src2_is_link = 1'b1;
				ctrl.rd_write     = 1'b1;
				ctrl.imm_fmt      = dec_pipe_pkg::imm_j;
			end
			rv_isa_pkg::op_jalr:
			begin
				ctrl.jalr         = 1'b1;	// target is src1 + imm in EX
				ctrl.use_rs1      = 1'b1;
				ctrl.src2_is_link = 1'b1;
				ctrl.rd_write     = 1'b1;
			end
			rv_isa_pkg::op_branch:
			begin
				ctrl.use_rs1         = 1'b1;
				ctrl.use_rs2_as_src2 = 1'b1;
				ctrl.imm_fmt         = dec_pipe_pkg::imm_b;
				// compare flavour follows funct3[2:1]
				if (!funct3[2])
					ctrl.alu_op = dec_pipe_pkg::alu_sub;
				else if (!funct3[1])
					ctrl.alu_op = dec_pipe_pkg::alu_slt;
				else
					ctrl.alu_op = dec_pipe_pkg::alu_sltu;
				case (funct3)
					rv_isa_pkg::f3_beq:  ctrl.br_op = dec_pipe_pkg::br_beq;
					rv_isa_pkg::f3_bne:  ctrl.br_op = dec_pipe_pkg::br_bne;
					rv_isa_pkg::f3_blt:  ctrl.br_op = dec_pipe_pkg::br_blt;
					rv_isa_pkg::f3_bge:  ctrl.br_op = dec_pipe_pkg::br_bge;
					rv_isa_pkg::f3_bltu: ctrl.br_op = dec_pipe_pkg::br_bltu;
					rv_isa_pkg::f3_bgeu: ctrl.br_op = dec_pipe_pkg::br_bgeu;
					default:             ctrl.illegal = 1'b1;
				endcase
			end
			rv_isa_pkg::op_load:
			begin
				ctrl.load            = 1'b1;
				ctrl.mem_unsigned    = funct3[2];	// lbu, lhu
				ctrl.use_rs1         = 1'b1;
				ctrl.use_imm_as_src2 = 1'b1;
				ctrl.rd_write        = 1'b1;
				ctrl.illegal         = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			end
			rv_isa_pkg::op_store:
			begin
				ctrl.store           = 1'b1;
				ctrl.use_rs1         = 1'b1;
				ctrl.use_imm_as_src2 = 1'b1;
				ctrl.imm_fmt         = dec_pipe_pkg::imm_s;
				ctrl.illegal         = funct3[2] || (funct3[1:0] == 2'b11);
			end
			rv_isa_pkg::op_alu_ir:
			begin
				// only srai carries the alt bit, addi never turns into sub
				ctrl.alu_op          = alu_fn(funct3,
					(funct3 == rv_isa_pkg::f3_sr) && (funct7 == rv_isa_pkg::f7_alt));
				ctrl.use_rs1         = 1'b1;
				ctrl.use_imm_as_src2 = 1'b1;
				ctrl.rd_write        = 1'b1;
			end
			rv_isa_pkg::op_alu_rr:
			begin
				ctrl.alu_op          = alu_fn(funct3, funct7 == rv_isa_pkg::f7_alt);
				ctrl.use_rs1         = 1'b1;
				ctrl.use_rs2_as_src2 = 1'b1;
				ctrl.rd_write        = 1'b1;
				ctrl.illegal         = !rr_legal;	// catches the M extension
			end
			default:
				ctrl.illegal = 1'b1;
		endcase

		// an illegal instruction must not act on any state
		if (ctrl.illegal)
		begin
			ctrl.alu_op   = dec_pipe_pkg::alu_none;
			ctrl.br_op    = dec_pipe_pkg::br_none;
			ctrl.jal      = 1'b0;
			ctrl.jalr     = 1'b0;
			ctrl.load     = 1'b0;
			ctrl.store    = 1'b0;
			ctrl.rd_write = 1'b0;
		end
	end

endmodule

// File: hw/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  logic [rv_isa_pkg::xlen-1:0] instr,
	input  dec_pipe_pkg::imm_fmt_t      fmt,
	output logic [rv_isa_pkg::xlen-1:0] imm
);

	logic sign;	// instr[31] is the sign bit in every format

	assign sign = instr[31];

	always_comb
	begin
		case (fmt)
			dec_pipe_pkg::imm_s:
				imm = {{20{sign}}, instr[31:25], instr[11:7]};
			dec_pipe_pkg::imm_b:	// bit 0 always zero
				imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
			dec_pipe_pkg::imm_u:
				imm = {instr[31:12], 12'b0};
			dec_pipe_pkg::imm_j:
				imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:	// i format
				imm = {{20{sign}}, instr[31:20]};
		endcase
	end

endmodule

// File: hw/gpr_file.sv
`timescale 1ns/1ps

module gpr_file #(
	parameter int num_gprs_p = rv_isa_pkg::num_gprs
) (
	input  logic                              cpu_clk,
	input  logic                              cpu_rstn,
	input  dec_pipe_pkg::fwd_t                wb,	// write port
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
	output logic [rv_isa_pkg::xlen-1:0]       rd1,
	output logic [rv_isa_pkg::xlen-1:0]       rd2
);

	logic [rv_isa_pkg::xlen-1:0] regs [num_gprs_p];

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 0; i < num_gprs_p; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb.valid && (wb.rd != '0))
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	// x0 hardwired, new writes show up from the next cycle
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  dec_pipe_pkg::dec_ctrl_t           ctrl,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
	input  logic [rv_isa_pkg::xlen-1:0]       rf1,	// register file data
	input  logic [rv_isa_pkg::xlen-1:0]       rf2,
	input  logic [rv_isa_pkg::xlen-1:0]       imm,
	input  logic [rv_isa_pkg::xlen-1:0]       pc,
	input  logic [rv_isa_pkg::xlen-1:0]       pc_plus4,
	input  dec_pipe_pkg::fwd_t                fwd_ex,
	input  dec_pipe_pkg::fwd_t                fwd_mem,
	input  dec_pipe_pkg::fwd_t                wb,
	output logic [rv_isa_pkg::xlen-1:0]       src1,
	output logic [rv_isa_pkg::xlen-1:0]       src2,
	output logic [rv_isa_pkg::xlen-1:0]       store_data
);

	logic [rv_isa_pkg::xlen-1:0] rs1_val;
	logic [rv_isa_pkg::xlen-1:0] rs2_val;

	// youngest producer wins: ex, then mem, then wb
	function automatic logic [rv_isa_pkg::xlen-1:0] fwd_pick(
		input logic [rv_isa_pkg::reg_addr_w-1:0] idx,
		input logic [rv_isa_pkg::xlen-1:0]       rf,
		input dec_pipe_pkg::fwd_t                f_ex,
		input dec_pipe_pkg::fwd_t                f_mem,
		input dec_pipe_pkg::fwd_t                f_wb
	);
		if (idx == '0)
			fwd_pick = '0;
		else if (f_ex.valid && (f_ex.rd == idx))
			fwd_pick = f_ex.data;
		else if (f_mem.valid && (f_mem.rd == idx))
			fwd_pick = f_mem.data;
		else if (f_wb.valid && (f_wb.rd == idx))
			fwd_pick = f_wb.data;	// rf not written yet
		else
			fwd_pick = rf;
	endfunction

	assign rs1_val    = fwd_pick(rs1, rf1, fwd_ex, fwd_mem, wb);
	assign rs2_val    = fwd_pick(rs2, rf2, fwd_ex, fwd_mem, wb);
	assign store_data = rs2_val;

	always_comb
	begin
		if (ctrl.src1_is_pc)
			src1 = pc;
		else if (ctrl.use_rs1)
			src1 = rs1_val;
		else
			src1 = '0;	// lui, jal

		if (ctrl.src2_is_link)
			src2 = pc_plus4;
		else if (ctrl.use_rs2_as_src2)
			src2 = rs2_val;
		else
			src2 = imm;
	end

endmodule

// File: hw/dec_ex_reg.sv
`timescale 1ns/1ps

module dec_ex_reg (
	input  logic                        cpu_clk,
	input  logic                        cpu_rstn,
	input  logic                        flush,
	input  logic                        ex_ready,
	input  dec_pipe_pkg::fetch_pkt_t    fetch,
	input  dec_pipe_pkg::dec_ctrl_t     ctrl,
	input  logic [rv_isa_pkg::xlen-1:0] src1,
	input  logic [rv_isa_pkg::xlen-1:0] src2,
	input  logic [rv_isa_pkg::xlen-1:0] store_data,
	input  logic [rv_isa_pkg::xlen-1:0] imm,
	output dec_pipe_pkg::ex_pkt_t       ex
);

	dec_pipe_pkg::ex_pkt_t pkt_d;	// next packet, already a bubble if not live
	dec_pipe_pkg::ex_pkt_t ctl_q;	// control fields, reset
	dec_pipe_pkg::ex_pkt_t dat_q;	// data fields, no reset

	always_comb
	begin
		pkt_d              = '0;
		pkt_d.valid        = fetch.valid && !flush;
		pkt_d.alu_op       = ctrl.alu_op;
		pkt_d.br_op        = ctrl.br_op;
		pkt_d.jalr         = ctrl.jalr;
		pkt_d.load         = ctrl.load;
		pkt_d.store        = ctrl.store;
		pkt_d.mem_size     = ctrl.mem_size;
		pkt_d.mem_unsigned = ctrl.mem_unsigned;
		pkt_d.illegal      = ctrl.illegal;
		pkt_d.rd_write     = ctrl.rd_write;
		pkt_d.rd           = fetch.instr[rv_isa_pkg::rd_lsb +: rv_isa_pkg::reg_addr_w];
		pkt_d.src1         = src1;
		pkt_d.src2         = src2;
		pkt_d.store_data   = store_data;
		pkt_d.imm          = imm;
		pkt_d.pc           = fetch.pc;
		pkt_d.pc_plus4     = fetch.pc_plus4;
		if (!pkt_d.valid)
		begin
			pkt_d.alu_op   = dec_pipe_pkg::alu_none;
			pkt_d.br_op    = dec_pipe_pkg::br_none;
			pkt_d.jalr     = 1'b0;
			pkt_d.load     = 1'b0;
			pkt_d.store    = 1'b0;
			pkt_d.illegal  = 1'b0;
			pkt_d.rd_write = 1'b0;
		end
	end

	// flush also kills a held packet under back-pressure
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			ctl_q <= '0;
		else if (flush || ex_ready)
			ctl_q <= pkt_d;
	end

	always_ff @(posedge cpu_clk)
	begin
		if (ex_ready)
			dat_q <= pkt_d;
	end

	always_comb
	begin
		ex          = dat_q;
		ex.valid    = ctl_q.valid;
		ex.alu_op   = ctl_q.alu_op;
		ex.br_op    = ctl_q.br_op;
		ex.jalr     = ctl_q.jalr;
		ex.load     = ctl_q.load;
		ex.store    = ctl_q.store;
		ex.illegal  = ctl_q.illegal;
		ex.rd_write = ctl_q.rd_write;
	end

endmodule

// File: hw/dec_stage.sv
`timescale 1ns/1ps

module dec_stage (
	input  logic                     cpu_clk,
	input  logic                     cpu_rstn,
	input  dec_pipe_pkg::fetch_pkt_t fetch,
	output logic                     dec_ready,
	output dec_pipe_pkg::ex_pkt_t    ex,
	input  logic                     ex_ready,
	input  logic                     flush,		// mispredict or exception
	input  dec_pipe_pkg::fwd_t       fwd_ex,
	input  dec_pipe_pkg::fwd_t       fwd_mem,
	input  dec_pipe_pkg::fwd_t       wb		// rf write and forward
);

	dec_pipe_pkg::dec_ctrl_t           ctrl;
	logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
	logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
	logic [rv_isa_pkg::xlen-1:0]       imm;
	logic [rv_isa_pkg::xlen-1:0]       rf1;
	logic [rv_isa_pkg::xlen-1:0]       rf2;
	logic [rv_isa_pkg::xlen-1:0]       src1;
	logic [rv_isa_pkg::xlen-1:0]       src2;
	logic [rv_isa_pkg::xlen-1:0]       store_data;

	assign rs1 = fetch.instr[rv_isa_pkg::rs1_lsb +: rv_isa_pkg::reg_addr_w];
	assign rs2 = fetch.instr[rv_isa_pkg::rs2_lsb +: rv_isa_pkg::reg_addr_w];

	// no stall source of our own
	assign dec_ready = ex_ready;

	instr_decoder u_dec (
		.instr (fetch.instr),
		.ctrl  (ctrl)
	);

	imm_gen u_imm (
		.instr (fetch.instr),
		.fmt   (ctrl.imm_fmt),
		.imm   (imm)
	);

	gpr_file #(
		.num_gprs_p (rv_isa_pkg::num_gprs)
	) u_gprs (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb       (wb),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd1      (rf1),
		.rd2      (rf2)
	);

	operand_select u_opsel (
		.ctrl       (ctrl),
		.rs1        (rs1),
		.rs2        (rs2),
		.rf1        (rf1),
		.rf2        (rf2),
		.imm        (imm),
		.pc         (fetch.pc),
		.pc_plus4   (fetch.pc_plus4),
		.fwd_ex     (fwd_ex),
		.fwd_mem    (fwd_mem),
		.wb         (wb),
		.src1       (src1),
		.src2       (src2),
		.store_data (store_data)
	);

	dec_ex_reg u_dec_ex (
		.cpu_clk    (cpu_clk),
		.cpu_rstn   (cpu_rstn),
		.flush      (flush),
		.ex_ready   (ex_ready),
		.fetch      (fetch),
		.ctrl       (ctrl),
		.src1       (src1),
		.src2       (src2),
		.store_data (store_data),
		.imm        (imm),
		.ex         (ex)
	);

endmodule

// File: verification/dec_stage_tb.sv
`timescale 1ns/1ps

module dec_stage_tb;

	localparam int ready_limit = 20;	// negedges before a wait gives up

	// flags packed as rd_write load store jalr illegal
	localparam logic [4:0] fl_none = 5'b00000;
	localparam logic [4:0] fl_wr   = 5'b10000;
	localparam logic [4:0] fl_ld   = 5'b11000;
	localparam logic [4:0] fl_st   = 5'b00100;
	localparam logic [4:0] fl_jr   = 5'b10010;
	localparam logic [4:0] fl_ill  = 5'b00001;

	// field groups a row checks
	localparam logic [3:0] c_src = 4'b0001;
	localparam logic [3:0] c_imm = 4'b0010;
	localparam logic [3:0] c_sd  = 4'b0100;
	localparam logic [3:0] c_mem = 4'b1000;

	localparam dec_pipe_pkg::fwd_t nf = '0;	// no forwarding

	typedef struct packed {
		logic [31:0]           instr;
		logic [31:0]           pc;
		dec_pipe_pkg::fwd_t    f_ex;
		dec_pipe_pkg::fwd_t    f_mem;
		dec_pipe_pkg::fwd_t    f_wb;
		dec_pipe_pkg::alu_op_t alu_op;
		dec_pipe_pkg::br_op_t  br_op;
		logic [31:0]           src1;
		logic [31:0]           src2;
		logic [31:0]           imm;
		logic [31:0]           sd;
		logic [4:0]            flags;
		logic                  mem_uns;
		logic [1:0]            mem_size;
		logic [3:0]            chk;
	} row_t;

	logic                     cpu_clk;
	logic                     cpu_rstn;
	dec_pipe_pkg::fetch_pkt_t fetch;
	logic                     dec_ready;
	dec_pipe_pkg::ex_pkt_t    ex;
	logic                     ex_ready;
	logic                     flush;
	dec_pipe_pkg::fwd_t       fwd_ex;
	dec_pipe_pkg::fwd_t       fwd_mem;
	dec_pipe_pkg::fwd_t       wb;

	logic [31:0] lcg_state;
	logic [31:0] m [32];	// register model that follows every wb write
	row_t        rows [$];
	string       names [$];
	int          tests;
	int          failed;
	int          errs;
	int          test_errs;

	dec_stage dut0 (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.fetch     (fetch),
		.dec_ready (dec_ready),
		.ex        (ex),
		.ex_ready  (ex_ready),
		.flush     (flush),
		.fwd_ex    (fwd_ex),
		.fwd_mem   (fwd_mem),
		.wb        (wb)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #20 cpu_clk = ~cpu_clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic dec_pipe_pkg::fwd_t fwd_of(input logic [4:0] idx, input logic [31:0] val);
		return '{1'b1, idx, val};
	endfunction

	// one instruction encoder per format
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_alu_rr};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
	endfunction

	task automatic check(input string test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, field, exp, act);
			errs++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errs != 0)
			failed++;
		$display("test %-14s %s", name, (test_errs == 0) ? "ok" : "mismatch");
		test_errs = 0;
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic wait_ready(input string what);
		int n;
		n = 0;
		while (dec_ready !== 1'b1)
		begin
			if (n >= ready_limit)
				abort_run({"dec_ready stayed low in ", what});
			@(negedge cpu_clk);
			n++;
		end
	endtask

	task automatic drive_fetch(input logic valid, input logic [31:0] instr,
		input logic [31:0] pc);
		fetch.valid    = valid;
		fetch.instr    = instr;
		fetch.pc       = pc;
		fetch.pc_plus4 = pc + 32'd4;
	endtask

	task automatic check_idle(input string name);
		check(name, "valid", 32'd0, ex.valid);
		check(name, "rd_write", 32'd0, ex.rd_write);
		check(name, "load", 32'd0, ex.load);
		check(name, "store", 32'd0, ex.store);
		check(name, "jalr", 32'd0, ex.jalr);
	endtask

	task automatic add_row(input string name, input logic [31:0] instr,
		input logic [31:0] pc, input dec_pipe_pkg::fwd_t fe, fm, fw,
		input dec_pipe_pkg::alu_op_t op, input dec_pipe_pkg::br_op_t br,
		input logic [31:0] s1, s2, imm, sd, input logic [4:0] flags,
		input logic uns, input logic [1:0] size, input logic [3:0] chk);
		row_t r;
		r = '{instr, pc, fe, fm, fw, op, br, s1, s2, imm, sd, flags, uns, size, chk};
		rows.push_back(r);
		names.push_back(name);
		if (fw.valid && (fw.rd != 5'd0))
			m[fw.rd] = fw.data;	// lands in the rf at this row's edge
	endtask

	task automatic build_table();
		logic [31:0] d [9];
		for (int i = 0; i < 9; i++)
			d[i] = lcg_next();
		add_row("add", r_type(7'h00, 5'd3, 5'd2, 3'd0, 5'd5), 32'h100, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[2], m[3], 0, m[3],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("sub", r_type(7'h20, 5'd4, 5'd6, 3'd0, 5'd7), 32'h104, nf, nf, nf,
			dec_pipe_pkg::alu_sub, dec_pipe_pkg::br_none, m[6], m[4], 0, m[4],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("sra", r_type(7'h20, 5'd9, 5'd8, 3'd5, 5'd10), 32'h108, nf, nf, nf,
			dec_pipe_pkg::alu_sra, dec_pipe_pkg::br_none, m[8], m[9], 0, m[9],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("sltu", r_type(7'h00, 5'd11, 5'd12, 3'd3, 5'd13), 32'h10c, nf, nf, nf,
			dec_pipe_pkg::alu_sltu, dec_pipe_pkg::br_none, m[12], m[11], 0, m[11],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("and_x0", r_type(7'h00, 5'd0, 5'd0, 3'd7, 5'd14), 32'h110, nf, nf, nf,
			dec_pipe_pkg::alu_and, dec_pipe_pkg::br_none, 0, 0, 0, 0,
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("addi", i_type(12'hffc, 5'd15, 3'd0, 5'd16, rv_isa_pkg::op_alu_ir), 32'h114,
			nf, nf, nf, dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[15], 32'hffff_fffc,
			32'hffff_fffc, 0, fl_wr, 1'b0, 2'd0, c_src | c_imm);
		add_row("srai", i_type(12'h403, 5'd17, 3'd5, 5'd18, rv_isa_pkg::op_alu_ir), 32'h118,
			nf, nf, nf, dec_pipe_pkg::alu_sra, dec_pipe_pkg::br_none, m[17], 32'h403,
			32'h403, 0, fl_wr, 1'b0, 2'd0, c_src | c_imm);
		add_row("lui", u_type(20'hdead5, 5'd19, rv_isa_pkg::op_lui), 32'h11c, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, 0, 32'hdead_5000, 32'hdead_5000, 0,
			fl_wr, 1'b0, 2'd0, c_src | c_imm);
		add_row("auipc", u_type(20'h12345, 5'd20, rv_isa_pkg::op_auipc), 32'h120, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, 32'h120, 32'h1234_5000,
			32'h1234_5000, 0, fl_wr, 1'b0, 2'd0, c_src | c_imm);
		add_row("jal", j_type(21'h1a_b3c6, 5'd1), 32'h124, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, 0, 32'h128, 32'hfffa_b3c6, 0,
			fl_wr, 1'b0, 2'd0, c_src | c_imm);
		add_row("jalr", i_type(12'h010, 5'd21, 3'd0, 5'd1, rv_isa_pkg::op_jalr), 32'h128,
			nf, nf, nf, dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[21], 32'h12c,
			32'h10, 0, fl_jr, 1'b0, 2'd0, c_src | c_imm);
		add_row("lw", i_type(12'h804, 5'd22, 3'd2, 5'd23, rv_isa_pkg::op_load), 32'h12c,
			nf, nf, nf, dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[22], 32'hffff_f804,
			32'hffff_f804, 0, fl_ld, 1'b0, 2'd2, c_src | c_imm | c_mem);
		add_row("lbu", i_type(12'h001, 5'd24, 3'd4, 5'd25, rv_isa_pkg::op_load), 32'h130,
			nf, nf, nf, dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[24], 32'h1,
			32'h1, 0, fl_ld, 1'b1, 2'd0, c_src | c_imm | c_mem);
		add_row("sw", s_type(12'hff0, 5'd26, 5'd27, 3'd2), 32'h134, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[27], 32'hffff_fff0, 32'hffff_fff0,
			m[26], fl_st, 1'b0, 2'd2, c_src | c_imm | c_sd | c_mem);
		add_row("sb", s_type(12'h07f, 5'd28, 5'd29, 3'd0), 32'h138, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[29], 32'h7f, 32'h7f,
			m[28], fl_st, 1'b0, 2'd0, c_src | c_imm | c_sd | c_mem);
		// branches compare rs1 against rs2
		add_row("beq", b_type(13'h0ffe, 5'd3, 5'd2, 3'd0), 32'h13c, nf, nf, nf,
			dec_pipe_pkg::alu_sub, dec_pipe_pkg::br_beq, m[2], m[3], 32'hffe, m[3],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		add_row("bne", b_type(13'h1ff0, 5'd5, 5'd4, 3'd1), 32'h140, nf, nf, nf,
			dec_pipe_pkg::alu_sub, dec_pipe_pkg::br_bne, m[4], m[5], 32'hffff_fff0, m[5],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		add_row("blt", b_type(13'h0008, 5'd7, 5'd6, 3'd4), 32'h144, nf, nf, nf,
			dec_pipe_pkg::alu_slt, dec_pipe_pkg::br_blt, m[6], m[7], 32'h8, m[7],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		add_row("bge", b_type(13'h1800, 5'd9, 5'd8, 3'd5), 32'h148, nf, nf, nf,
			dec_pipe_pkg::alu_slt, dec_pipe_pkg::br_bge, m[8], m[9], 32'hffff_f800, m[9],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		add_row("bltu", b_type(13'h07fe, 5'd11, 5'd10, 3'd6), 32'h14c, nf, nf, nf,
			dec_pipe_pkg::alu_sltu, dec_pipe_pkg::br_bltu, m[10], m[11], 32'h7fe, m[11],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		add_row("bgeu", b_type(13'h0020, 5'd13, 5'd12, 3'd7), 32'h150, nf, nf, nf,
			dec_pipe_pkg::alu_sltu, dec_pipe_pkg::br_bgeu, m[12], m[13], 32'h20, m[13],
			fl_none, 1'b0, 2'd0, c_src | c_imm | c_sd);
		// add x30, x5, x6 under different forwarding mixes
		add_row("fwd_ex_first", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd30), 32'h154,
			fwd_of(5'd5, d[0]), fwd_of(5'd5, d[1]), fwd_of(5'd5, d[2]),
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, d[0], m[6], 0, m[6],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("fwd_mem_next", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd30), 32'h158,
			nf, fwd_of(5'd5, d[3]), fwd_of(5'd5, d[4]),
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, d[3], m[6], 0, m[6],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("fwd_wb_rs2", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd30), 32'h15c,
			nf, nf, fwd_of(5'd6, d[5]),
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[5], d[5], 0, d[5],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("fwd_ex_rs2", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd30), 32'h160,
			fwd_of(5'd6, d[6]), nf, fwd_of(5'd6, d[7]),
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[5], d[6], 0, d[6],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("rf_after_wb", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd30), 32'h164, nf, nf, nf,
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, m[5], m[6], 0, m[6],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("fwd_x0", r_type(7'h00, 5'd6, 5'd0, 3'd0, 5'd31), 32'h168,
			fwd_of(5'd0, d[8]), nf, fwd_of(5'd0, d[8]),
			dec_pipe_pkg::alu_add, dec_pipe_pkg::br_none, 0, m[6], 0, m[6],
			fl_wr, 1'b0, 2'd0, c_src | c_sd);
		add_row("mul", r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd3), 32'h16c, nf, nf, nf,
			dec_pipe_pkg::alu_none, dec_pipe_pkg::br_none, 0, 0, 0, 0,
			fl_ill, 1'b0, 2'd0, 4'b0000);
		add_row("bad_opcode", 32'h0000_007f, 32'h170, nf, nf, nf,
			dec_pipe_pkg::alu_none, dec_pipe_pkg::br_none, 0, 0, 0, 0,
			fl_ill, 1'b0, 2'd0, 4'b0000);
	endtask

	task automatic apply_row(input string name, input row_t r);
		drive_fetch(1'b1, r.instr, r.pc);
		fwd_ex  = r.f_ex;
		fwd_mem = r.f_mem;
		wb      = r.f_wb;
		wait_ready(name);
		@(posedge cpu_clk);
		@(negedge cpu_clk);	// packet visible one edge later
		check(name, "valid", 32'd1, ex.valid);
		check(name, "alu_op", r.alu_op, ex.alu_op);
		check(name, "br_op", r.br_op, ex.br_op);
		check(name, "rd", r.instr[11:7], ex.rd);
		check(name, "pc", r.pc, ex.pc);
		check(name, "pc_plus4", r.pc + 32'd4, ex.pc_plus4);
		check(name, "flags", r.flags, {ex.rd_write, ex.load, ex.store, ex.jalr, ex.illegal});
		if ((r.chk & c_src) != 0)
		begin
			check(name, "src1", r.src1, ex.src1);
			check(name, "src2", r.src2, ex.src2);
		end
		if ((r.chk & c_imm) != 0)
			check(name, "imm", r.imm, ex.imm);
		if ((r.chk & c_sd) != 0)
			check(name, "store_data", r.sd, ex.store_data);
		if ((r.chk & c_mem) != 0)
		begin
			check(name, "mem_size", r.mem_size, ex.mem_size);
			check(name, "mem_unsigned", r.mem_uns, ex.mem_unsigned);
		end
		end_test(name);
	endtask

	initial
	begin
		lcg_state = 32'h7af1_40d7;
		tests     = 0;
		failed    = 0;
		errs      = 0;
		test_errs = 0;
		cpu_rstn  = 1'b0;
		ex_ready  = 1'b1;
		flush     = 1'b0;
		fwd_ex    = nf;
		fwd_mem   = nf;
		wb        = nf;
		// a load waits on fetch while valid is low
		drive_fetch(1'b0, i_type(12'h004, 5'd1, 3'd2, 5'd2, rv_isa_pkg::op_load), 32'h0);
		m[0] = '0;
		for (int i = 1; i < 32; i++)
			m[i] = lcg_next();
		repeat (3) @(posedge cpu_clk);
		@(negedge cpu_clk);
		cpu_rstn = 1'b1;
		check_idle("reset");
		end_test("reset");

		// fill the rf through wb while fetch stays idle
		for (int i = 1; i < 32; i++)
		begin
			wb = fwd_of(5'(i), m[i]);
			@(posedge cpu_clk);
			@(negedge cpu_clk);
			check_idle("idle");
		end
		wb = nf;
		end_test("idle");

		build_table();
		for (int i = 0; i < rows.size(); i++)
			apply_row(names[i], rows[i]);
		fwd_ex  = nf;
		fwd_mem = nf;
		wb      = nf;

		// or x9, x2, x3 then held under back-pressure
		drive_fetch(1'b1, r_type(7'h00, 5'd3, 5'd2, 3'd6, 5'd9), 32'h200);
		wait_ready("hold");
		@(posedge cpu_clk);
		@(negedge cpu_clk);
		ex_ready = 1'b0;
		drive_fetch(1'b1, i_type(12'h005, 5'd4, 3'd0, 5'd10, rv_isa_pkg::op_alu_ir), 32'h204);
		repeat (2) @(posedge cpu_clk);
		@(negedge cpu_clk);
		check("hold", "dec_ready", 32'd0, dec_ready);
		check("hold", "valid", 32'd1, ex.valid);
		check("hold", "alu_op", dec_pipe_pkg::alu_or, ex.alu_op);
		check("hold", "pc", 32'h200, ex.pc);
		check("hold", "rd", 32'd9, ex.rd);
		check("hold", "src1", m[2], ex.src1);
		check("hold", "src2", m[3], ex.src2);
		end_test("hold");

		ex_ready = 1'b1;
		wait_ready("release");
		@(posedge cpu_clk);
		@(negedge cpu_clk);
		check("release", "pc", 32'h204, ex.pc);
		check("release", "alu_op", dec_pipe_pkg::alu_add, ex.alu_op);
		check("release", "src1", m[4], ex.src1);
		check("release", "src2", 32'h5, ex.src2);
		end_test("release");

		// flush beats back-pressure
		ex_ready = 1'b0;
		flush    = 1'b1;
		drive_fetch(1'b1, r_type(7'h00, 5'd3, 5'd2, 3'd0, 5'd11), 32'h208);
		@(posedge cpu_clk);
		@(negedge cpu_clk);
		check("flush_held", "valid", 32'd0, ex.valid);
		check("flush_held", "rd_write", 32'd0, ex.rd_write);
		end_test("flush_held");

		ex_ready = 1'b1;
		@(posedge cpu_clk);
		@(negedge cpu_clk);
		check("flush_live", "valid", 32'd0, ex.valid);
		check("flush_live", "rd_write", 32'd0, ex.rd_write);
		end_test("flush_live");

		flush = 1'b0;
		drive_fetch(1'b0, b_type(13'h0010, 5'd3, 5'd2, 3'd1), 32'h20c);	// bne behind valid low
		@(posedge cpu_clk);
		@(negedge cpu_clk);
		check_idle("bubble");
		check("bubble", "alu_op", dec_pipe_pkg::alu_none, ex.alu_op);
		check("bubble", "br_op", dec_pipe_pkg::br_none, ex.br_op);
		end_test("bubble");

		$display("%0d tests, %0d failed, %0d mismatches", tests, failed, errs);
		if (errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: files.f
hw/rv_isa_pkg.sv
hw/dec_pipe_pkg.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/gpr_file.sv
hw/operand_select.sv
hw/dec_ex_reg.sv
hw/dec_stage.sv
verification/dec_stage_tb.sv

// File: Bender.yml
package:
  name: dec_stage

sources:
  - hw/rv_isa_pkg.sv
  - hw/dec_pipe_pkg.sv
  - hw/instr_decoder.sv
  - hw/imm_gen.sv
  - hw/gpr_file.sv
  - hw/operand_select.sv
  - hw/dec_ex_reg.sv
  - hw/dec_stage.sv
  - target: test
    files:
      - verification/dec_stage_tb.sv
